// File: Makefile
VERILATOR  ?= verilator
TOP        := mips_cpu_harvard_tb
FILELIST   := vlog.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
PASS_MSG   := All checks passed

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/mips_cpu_control.sv
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_control (
	input  mips_isa_pkg::instr_fields_t fields,
	output mips_ctrl_pkg::ctrl_t        ctrl
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	always_comb begin
		ctrl = ctrl_nop;
		case (fields.opcode)
			op_special: begin
				ctrl.reg_dst_rd = 1'b1;
				ctrl.wb_sel = wb_alu;
				case (fields.tail.r.funct)
					fn_addu: ctrl.alu_op = alu_add;
					fn_subu: ctrl.alu_op = alu_sub;
					fn_and:  ctrl.alu_op = alu_and;
					fn_or:   ctrl.alu_op = alu_or;
					fn_xor:  ctrl.alu_op = alu_xor;
					fn_slt:  ctrl.alu_op = alu_slt;
					fn_sltu: ctrl.alu_op = alu_sltu;
					fn_sll: begin
						ctrl.alu_op = alu_sll;
						ctrl.shift_imm = 1'b1;
					end
					fn_srl: begin
						ctrl.alu_op = alu_srl;
						ctrl.shift_imm = 1'b1;
					end
					fn_sra: begin
						ctrl.alu_op = alu_sra;
						ctrl.shift_imm = 1'b1;
					end
					fn_jr: begin
						ctrl.wb_sel = wb_none;
						ctrl.jump_reg = 1'b1;
					end
					default: ctrl = ctrl_nop;
				endcase
			end
			op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
				ctrl.imm_src = 1'b1;
				ctrl.wb_sel = wb_alu;
				ctrl.zero_ext = (fields.opcode == op_andi) || (fields.opcode == op_ori) ||
					(fields.opcode == op_xori);
				case (fields.opcode)
					op_slti:  ctrl.alu_op = alu_slt;
					op_sltiu: ctrl.alu_op = alu_sltu; // sign-extended, compared unsigned.
					op_andi:  ctrl.alu_op = alu_and;
					op_ori:   ctrl.alu_op = alu_or;
					op_xori:  ctrl.alu_op = alu_xor;
					op_lui:   ctrl.alu_op = alu_lui;
					default:  ctrl.alu_op = alu_add;
				endcase
			end
			op_lw: begin
				ctrl.imm_src = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.wb_sel = wb_mem;
			end
			op_sw: begin
				ctrl.imm_src = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			op_beq: ctrl.branch_eq = 1'b1;
			op_bne: ctrl.branch_ne = 1'b1;
			op_j:   ctrl.jump = 1'b1;
			default: ctrl = ctrl_nop; // unknown opcode is a no-op.
		endcase
	end

	// a load and a store never share one instruction.
	always_comb begin
		assert (!(ctrl.mem_read && ctrl.mem_write))
			else $error("control asserts both mem_read and mem_write");
	end

endmodule

`default_nettype wire

// File: hw/mips_cpu_execute.sv
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_execute (
	input  mips_isa_pkg::instr_fields_t fields,
	input  mips_ctrl_pkg::ctrl_t        ctrl,
	input  mips_isa_pkg::word_t         rs_data,
	input  mips_isa_pkg::word_t         rt_data,
	input  mips_isa_pkg::word_t         pc,
	input  mips_isa_pkg::word_t         data_readdata,
	input  logic                        halted,
	output mips_isa_pkg::word_t         data_address,
	output mips_isa_pkg::word_t         data_writedata,
	output logic                        data_read,
	output logic                        data_write,
	output mips_isa_pkg::reg_addr_t     wr_addr,
	output mips_isa_pkg::word_t         wr_data,
	output logic                        wr_en,
	output logic                        branch_taken,
	output mips_isa_pkg::word_t         target
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	word_t imm_ext, op_a, op_b, alu_y, slot_pc;
	logic eq;

	always_comb begin
		imm_ext = ctrl.zero_ext ? {16'h0000, fields.tail.imm16} :
			{{16{fields.tail.imm16[15]}}, fields.tail.imm16};
		op_a = ctrl.shift_imm ? {27'h0, fields.tail.r.shamt} : rs_data;
		op_b = ctrl.imm_src ? imm_ext : rt_data;
	end

	always_comb begin
		case (ctrl.alu_op)
			alu_add:  alu_y = op_a + op_b;
			alu_sub:  alu_y = op_a - op_b;
			alu_and:  alu_y = op_a & op_b;
			alu_or:   alu_y = op_a | op_b;
			alu_xor:  alu_y = op_a ^ op_b;
			alu_slt:  alu_y = {31'h0, $signed(op_a) < $signed(op_b)};
			alu_sltu: alu_y = {31'h0, op_a < op_b};
			alu_sll:  alu_y = op_b << op_a[4:0];
			alu_srl:  alu_y = op_b >> op_a[4:0];
			alu_sra:  alu_y = $unsigned($signed(op_b) >>> op_a[4:0]);
			alu_lui:  alu_y = {op_b[15:0], 16'h0000};
			default:  alu_y = op_a + op_b;
		endcase
	end

	// targets are relative to the delay slot.
	assign slot_pc = pc + 32'd4;
	assign eq = (rs_data == rt_data);

	always_comb begin
		branch_taken = ctrl.jump || ctrl.jump_reg || (ctrl.branch_eq && eq) ||
			(ctrl.branch_ne && !eq);
		if (ctrl.jump_reg) begin
			target = rs_data;
		end else if (ctrl.jump) begin
			target = {slot_pc[31:28], fields.rs, fields.rt, fields.tail, 2'b00};
		end else begin
			target = slot_pc + {imm_ext[29:0], 2'b00};
		end
	end

	assign data_address = alu_y;
	assign data_writedata = rt_data;
	assign data_read = ctrl.mem_read && !halted;
	assign data_write = ctrl.mem_write && !halted;

	assign wr_addr = ctrl.reg_dst_rd ? fields.tail.r.rd : fields.rt;
	assign wr_data = (ctrl.wb_sel == wb_mem) ? data_readdata : alu_y;
	assign wr_en = (ctrl.wb_sel != wb_none) && !halted;

	always_comb begin
		assert (!(data_read || data_write) || (data_address[1:0] == 2'b00))
			else $error("unaligned data access at %h", data_address);
	end

endmodule

`default_nettype wire

// File: hw/mips_cpu_harvard.sv
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_harvard #(
	parameter mips_isa_pkg::word_t reset_vector = 32'hBFC0_0000
) (
	input  logic        clk,
	input  logic        reset,
	output logic        active,
	output logic [31:0] register_v0,
	input  logic        clk_enable,
	output logic [31:0] instr_address,
	input  logic [31:0] instr_readdata,
	output logic [31:0] data_address,
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	instr_fields_t fields;
	ctrl_t ctrl;
	word_t rs_data, rt_data, v0, wr_data, target, pc;
	reg_addr_t wr_addr;
	logic wr_en, branch_taken, halted, exe_read, exe_write;

	// instruction memory delivers words byte-swapped.
	assign fields = {instr_readdata[7:0], instr_readdata[15:8],
		instr_readdata[23:16], instr_readdata[31:24]};

	mips_cpu_control u_control (
		.fields (fields),
		.ctrl   (ctrl)
	);

	mips_cpu_register_file u_register_file (
		.clk        (clk),
		.reset      (reset),
		.clk_enable (clk_enable),
		.rs_addr    (fields.rs),
		.rt_addr    (fields.rt),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.wr_en      (wr_en),
		.rs_data    (rs_data),
		.rt_data    (rt_data),
		.v0         (v0)
	);

	mips_cpu_execute u_execute (
		.fields         (fields),
		.ctrl           (ctrl),
		.rs_data        (rs_data),
		.rt_data        (rt_data),
		.pc             (pc),
		.data_readdata  (data_readdata),
		.halted         (halted),
		.data_address   (data_address),
		.data_writedata (data_writedata),
		.data_read      (exe_read),
		.data_write     (exe_write),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.wr_en          (wr_en),
		.branch_taken   (branch_taken),
		.target         (target)
	);

	mips_cpu_pc_update #(
		.reset_vector (reset_vector)
	) u_pc_update (
		.clk          (clk),
		.reset        (reset),
		.clk_enable   (clk_enable),
		.branch_taken (branch_taken),
		.target       (target),
		.pc           (pc),
		.halted       (halted)
	);

	assign instr_address = pc;
	assign active = reset || !halted;
	assign register_v0 = v0;
	assign data_read = exe_read && !reset;
	assign data_write = exe_write && clk_enable && !reset; // single-cycle strobe.

endmodule

`default_nettype wire

// File: hw/mips_cpu_pc_update.sv
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_pc_update #(
	parameter mips_isa_pkg::word_t reset_vector = 32'hBFC0_0000
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                clk_enable,
	input  logic                branch_taken,
	input  mips_isa_pkg::word_t target,
	output mips_isa_pkg::word_t pc,
	output logic                halted
);
	import mips_isa_pkg::*;

	logic pending;
	word_t pend_target;

	assign halted = (pc == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_vector;
			pending <= 1'b0;
		end else if (clk_enable && !halted) begin
			if (pending) begin
				pc <= pend_target; // delay slot done.
			end else begin
				pc <= pc + 32'd4;
			end
			pending <= branch_taken;
		end
	end

	always_ff @(posedge clk) begin
		if (clk_enable && !halted && branch_taken) begin
			pend_target <= target;
		end
	end

	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// File: hw/mips_cpu_register_file.sv
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_register_file (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    clk_enable,
	input  mips_isa_pkg::reg_addr_t rs_addr,
	input  mips_isa_pkg::reg_addr_t rt_addr,
	input  mips_isa_pkg::reg_addr_t wr_addr,
	input  mips_isa_pkg::word_t     wr_data,
	input  logic                    wr_en,
	output mips_isa_pkg::word_t     rs_data,
	output mips_isa_pkg::word_t     rt_data,
	output mips_isa_pkg::word_t     v0
);
	import mips_isa_pkg::*;

	word_t regs [0:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (clk_enable && wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];
	assign v0 = regs[2]; // live view of $v0.

	assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
		else $error("register 0 holds a nonzero value");

endmodule

`default_nettype wire

// File: hw/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_lui
	} alu_op_e;

	typedef enum logic [1:0] {
		wb_none = 2'd0,
		wb_alu  = 2'd1,
		wb_mem  = 2'd2
	} wb_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    imm_src;    // b operand from immediate.
		logic    zero_ext;
		logic    shift_imm;  // a operand from shamt.
		logic    reg_dst_rd;
		wb_sel_e wb_sel;
		logic    mem_read;
		logic    mem_write;
		logic    branch_eq;
		logic    branch_ne;
		logic    jump;
		logic    jump_reg;
	} ctrl_t;

	localparam ctrl_t ctrl_nop = '{
		alu_op: alu_add,
		imm_src: 1'b0,
		zero_ext: 1'b0,
		shift_imm: 1'b0,
		reg_dst_rd: 1'b0,
		wb_sel: wb_none,
		mem_read: 1'b0,
		mem_write: 1'b0,
		branch_eq: 1'b0,
		branch_ne: 1'b0,
		jump: 1'b0,
		jump_reg: 1'b0
	};

endpackage

`default_nettype wire

// File: hw/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [4:0] shamt_t;
	typedef logic [15:0] imm16_t;

	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_sltiu   = 6'h0b,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_srl  = 6'h02,
		fn_sra  = 6'h03,
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	// low half seen as r-type fields or as the immediate.
	typedef struct packed {
		reg_addr_t  rd;
		shamt_t     shamt;
		logic [5:0] funct;
	} r_tail_t;

	typedef union packed {
		r_tail_t r;
		imm16_t  imm16;
	} tail_t;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		tail_t      tail;
	} instr_fields_t;

endpackage

`default_nettype wire

// File: tb/mips_cpu_harvard_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_harvard_tb;
	import mips_isa_pkg::*;

	localparam word_t reset_vector = 32'hBFC0_0000;
	localparam int n_programs = 8;
	localparam int n_instr = 40;
	localparam int stall_program = 3;
	localparam time clk_period = 100;

	logic clk = 1'b0;
	logic reset, clk_enable, active, data_write, data_read;
	word_t register_v0, instr_address, instr_readdata, data_address, data_writedata;
	word_t data_readdata, ioff, iword;

	word_t prog [0:63];
	word_t dmem [0:63];
	word_t m_dmem [0:63];
	word_t m_regs [0:31];
	word_t m_pc, m_target, store_addr, store_data;
	logic m_pending, m_halted, store_pending;
	word_t seed = 32'haaf8_7a3a;
	int n_errors = 0;
	int n_checks = 0;
	int prog_num = 0;

	mips_cpu_harvard u_dut (
		.clk            (clk),
		.reset          (reset),
		.active         (active),
		.register_v0    (register_v0),
		.clk_enable     (clk_enable),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	always #(clk_period / 2) clk = ~clk;

	// instruction memory hands out byte-swapped words.
	assign ioff = instr_address - reset_vector;
	assign iword = (ioff < 32'd256) ? prog[ioff[7:2]] : '0;
	assign instr_readdata = {iword[7:0], iword[15:8], iword[23:16], iword[31:24]};
	assign data_readdata = dmem[data_address[7:2]]; // 64-word window.

	function automatic word_t lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_below(int n);
		return int'(lcg_next() >> 12) % n;
	endfunction

	function automatic reg_addr_t pick_reg();
		return reg_addr_t'(1 + rand_below(7));
	endfunction

	function automatic word_t fetch(word_t addr);
		word_t off;
		off = addr - reset_vector;
		return (off < 32'd256) ? prog[off[7:2]] : '0;
	endfunction

	function automatic word_t sext(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic check_word(string name, word_t expected, word_t actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("FAILED %s in program %0d: expected %h, actual %h", name, prog_num,
				expected, actual);
		end
	endtask

	task automatic check_bit(string name, logic expected, logic actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("FAILED %s in program %0d: expected %b, actual %b", name, prog_num,
				expected, actual);
		end
	endtask

	task automatic gen_program();
		logic [5:0] op;
		logic [5:0] fn;
		reg_addr_t rs;
		word_t tgt;
		int kind, k;
		logic last_ctrl;
		last_ctrl = 1'b0;
		for (int i = 0; i < 64; i++) begin
			prog[i] = '0;
			dmem[i] = lcg_next();
			m_dmem[i] = dmem[i];
		end
		for (int i = 0; i < n_instr; i++) begin
			kind = rand_below(16);
			if (i == 0) begin
				kind = 12 + rand_below(2); // memory op sits at the reset vector.
			end
			if (kind >= 14 && (last_ctrl || i > 37)) begin
				kind = 0; // no branch in a delay slot.
			end
			last_ctrl = (kind >= 14);
			case (kind)
				0, 1, 2, 3, 4, 5: begin
					case (rand_below(7))
						0: fn = fn_addu;
						1: fn = fn_subu;
						2: fn = fn_and;
						3: fn = fn_or;
						4: fn = fn_xor;
						5: fn = fn_slt;
						default: fn = fn_sltu;
					endcase
					prog[i] = {6'h00, pick_reg(), pick_reg(), pick_reg(), 5'd0, fn};
				end
				6, 7: begin
					case (rand_below(3))
						0: fn = fn_sll;
						1: fn = fn_srl;
						default: fn = fn_sra;
					endcase
					prog[i] = {6'h00, 5'd0, pick_reg(), pick_reg(), 5'(rand_below(32)), fn};
				end
				8, 9, 10, 11: begin
					case (rand_below(7))
						0: op = op_addiu;
						1: op = op_slti;
						2: op = op_sltiu;
						3: op = op_andi;
						4: op = op_ori;
						5: op = op_xori;
						default: op = op_lui;
					endcase
					rs = (op == op_lui) ? 5'd0 : pick_reg();
					prog[i] = {op, rs, pick_reg(), 16'(lcg_next() >> 10)};
				end
				12: prog[i] = {op_lw, 5'd0, pick_reg(), 8'h00, 6'(rand_below(64)), 2'b00};
				13: prog[i] = {op_sw, 5'd0, pick_reg(), 8'h00, 6'(rand_below(64)), 2'b00};
				default: begin
					k = rand_below((n_instr - i) < 4 ? (n_instr - i) : 4);
					tgt = reset_vector + 32'(4 * (i + 1 + k));
					case (rand_below(3))
						0: prog[i] = {op_beq, pick_reg(), pick_reg(), 16'(k)};
						1: prog[i] = {op_bne, pick_reg(), pick_reg(), 16'(k)};
						default: prog[i] = {op_j, tgt[27:2]};
					endcase
				end
			endcase
		end
		prog[n_instr] = {6'h00, 20'd0, fn_jr}; // jr $0, then a nop slot.
	endtask

	// reference ISA step for one enabled edge.
	task automatic model_step();
		word_t ins, a, b, se, res, tgt, addr;
		reg_addr_t dst;
		logic wb, taken;
		if (m_halted) begin
			return;
		end
		ins = fetch(m_pc);
		a = m_regs[ins[25:21]];
		b = m_regs[ins[20:16]];
		se = sext(ins[15:0]);
		addr = a + se;
		dst = ins[20:16];
		wb = 1'b1;
		taken = 1'b0;
		res = '0;
		tgt = m_pc + 32'd4 + {se[29:0], 2'b00};
		case (ins[31:26])
			op_special: begin
				dst = ins[15:11];
				case (ins[5:0])
					fn_addu: res = a + b;
					fn_subu: res = a - b;
					fn_and:  res = a & b;
					fn_or:   res = a | b;
					fn_xor:  res = a ^ b;
					fn_slt:  res = {31'd0, $signed(a) < $signed(b)};
					fn_sltu: res = {31'd0, a < b};
					fn_sll:  res = b << ins[10:6];
					fn_srl:  res = b >> ins[10:6];
					fn_sra:  res = $unsigned($signed(b) >>> ins[10:6]);
					fn_jr: begin
						wb = 1'b0;
						taken = 1'b1;
						tgt = a;
					end
					default: wb = 1'b0;
				endcase
			end
			op_addiu: res = a + se;
			op_slti:  res = {31'd0, $signed(a) < $signed(se)};
			op_sltiu: res = {31'd0, a < se};
			op_andi:  res = a & {16'h0000, ins[15:0]};
			op_ori:   res = a | {16'h0000, ins[15:0]};
			op_xori:  res = a ^ {16'h0000, ins[15:0]};
			op_lui:   res = {ins[15:0], 16'h0000};
			op_lw:    res = m_dmem[addr[7:2]];
			op_sw: begin
				wb = 1'b0;
				m_dmem[addr[7:2]] = b;
			end
			op_beq: begin
				wb = 1'b0;
				taken = (a == b);
			end
			op_bne: begin
				wb = 1'b0;
				taken = (a != b);
			end
			op_j: begin
				wb = 1'b0;
				taken = 1'b1;
				tgt = m_pc + 32'd4;
				tgt = {tgt[31:28], ins[25:0], 2'b00};
			end
			default: wb = 1'b0;
		endcase
		if (wb && dst != '0) begin
			m_regs[dst] = res;
		end
		m_pc = m_pending ? m_target : m_pc + 32'd4;
		m_pending = taken;
		if (taken) begin
			m_target = tgt;
		end
		m_halted = (m_pc == '0);
	endtask

	task automatic check_cycle(logic en);
		word_t ins, addr;
		logic is_lw, is_sw;
		ins = fetch(m_pc);
		is_lw = (ins[31:26] == op_lw) && !m_halted;
		is_sw = (ins[31:26] == op_sw) && !m_halted;
		addr = m_regs[ins[25:21]] + sext(ins[15:0]);
		check_word("instr_address", m_pc, instr_address);
		check_word("register_v0", m_regs[2], register_v0);
		check_bit("active", !m_halted, active);
		check_bit("data_read", is_lw, data_read);
		check_bit("data_write", is_sw && en, data_write);
		if (is_lw || is_sw) begin
			check_word("data_address", addr, data_address);
		end
		if (is_sw) begin
			check_word("data_writedata", m_regs[ins[20:16]], data_writedata);
		end
		store_pending = (data_write === 1'b1); // memory takes it at the next edge.
		store_addr = data_address;
		store_data = data_writedata;
	endtask

	task automatic run_cycle(input logic prev_en, output logic en);
		@(posedge clk);
		if (store_pending) begin
			dmem[store_addr[7:2]] = store_data;
		end
		if (prev_en) begin
			model_step();
		end
		#10;
		en = (prog_num == stall_program) ? (rand_below(4) != 0) : 1'b1;
		clk_enable = en;
		#10;
		check_cycle(en);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		clk_enable = 1'b1;
		for (int c = 0; c < 5; c++) begin
			@(posedge clk);
			#10;
			if (c == 4) begin
				reset = 1'b0;
			end
			#10;
			check_bit("reset active", 1'b1, active);
			check_word("reset instr_address", reset_vector, instr_address);
			if (c < 4) begin
				check_bit("reset data_read", 1'b0, data_read);
				check_bit("reset data_write", 1'b0, data_write);
			end
		end
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = '0;
		end
		m_pc = reset_vector;
		m_pending = 1'b0;
		m_halted = 1'b0;
		check_cycle(1'b1);
	endtask

	initial begin
		logic en;
		reset = 1'b1;
		clk_enable = 1'b0;
		store_pending = 1'b0;
		for (int i = 0; i < 64; i++) begin
			prog[i] = '0;
			dmem[i] = '0;
		end
		for (prog_num = 0; prog_num < n_programs; prog_num++) begin
			@(posedge clk);
			#10;
			gen_program();
			apply_reset();
			en = 1'b1;
			do begin
				run_cycle(en, en);
			end while (!m_halted);
			repeat (5) run_cycle(en, en); // halted core holds still.
			for (int i = 0; i < 64; i++) begin
				check_word("data memory", m_dmem[i], dmem[i]);
			end
		end
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#((n_programs * 60 + 20) * clk_period);
		$display("timeout: core never halted within %0d cycles", n_programs * 60 + 20);
		$display("%0d checks, %0d errors", n_checks, n_errors);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hw/mips_isa_pkg.sv
hw/mips_ctrl_pkg.sv
hw/mips_cpu_control.sv
hw/mips_cpu_register_file.sv
hw/mips_cpu_execute.sv
hw/mips_cpu_pc_update.sv
hw/mips_cpu_harvard.sv
tb/mips_cpu_harvard_tb.sv
